/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch
FLIST     ?= fetch.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* fetch.f */
+incdir+.
fetch_pkg.sv
fetch_bpu.sv
fetch_addr_map.sv
fetch_if0.sv
fetch_if1.sv
fetch_top.sv
tb_fetch.sv

/* fetch_addr_map.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_addr_map (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [2:0]            vseg,
  output logic [2:0]            pseg,
  output logic                  uncached,
  input  fetch_pkg::dmw_write_t dmw_write
);

  logic [`FETCH_WINDOWS-1:0] win_en;
  logic [`FETCH_WINDOWS-1:0] win_unc;
  logic [2:0]                win_vseg [`FETCH_WINDOWS];
  logic [2:0]                win_pseg [`FETCH_WINDOWS];

  // scan from the top so that window 0 has the last word.
  always_comb begin
    pseg     = vseg;
    uncached = 1'b0;
    for (int w = `FETCH_WINDOWS - 1; w >= 0; w--) begin
      if (win_en[w] && win_vseg[w] == vseg) begin
        pseg     = win_pseg[w];
        uncached = win_unc[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      win_en <= '0;
    end else if (dmw_write.valid) begin
      win_en[dmw_write.index] <= dmw_write.enable;
    end
  end

  always_ff @(posedge clk) begin
    if (dmw_write.valid) begin
      win_vseg[dmw_write.index] <= dmw_write.vseg;
      win_pseg[dmw_write.index] <= dmw_write.pseg;
      win_unc[dmw_write.index]  <= dmw_write.uncached;
    end
  end

endmodule

/* fetch_bpu.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_bpu (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [31:0]             pc,
  output logic [`FETCH_SLOTS-1:0] slot_valid,
  output logic [`FETCH_SLOTS-1:0] slot_jump,
  output logic [31:0]             next_pc,
  input  fetch_pkg::bpu_update_t  bpu_update
);

  localparam int SLOT_W = $clog2(`FETCH_SLOTS);
  localparam int GRP_W  = SLOT_W + 2;
  localparam int IDX_W  = $clog2(`FETCH_BTB_ENTRIES);
  localparam int TAG_W  = 32 - IDX_W - 2;

  logic [`FETCH_BTB_ENTRIES-1:0] btb_valid;
  logic [TAG_W-1:0]              btb_tag    [`FETCH_BTB_ENTRIES];
  logic [31:0]                   btb_target [`FETCH_BTB_ENTRIES];

  logic [`FETCH_SLOTS-1:0] hit;
  logic [31:0]             slot_target [`FETCH_SLOTS];
  logic [31:0]             seq_pc;
  logic                    found;
  logic [IDX_W-1:0]        upd_idx;
  logic [TAG_W-1:0]        upd_tag;

  // every slot of the group probes its own entry in parallel.
  for (genvar s = 0; s < `FETCH_SLOTS; s++) begin : g_slot
    logic [31:0]      slot_addr;
    logic [IDX_W-1:0] idx;

    assign slot_addr      = {pc[31:GRP_W], SLOT_W'(s), 2'b00};
    assign idx            = slot_addr[IDX_W+1:2];
    assign hit[s]         = btb_valid[idx] && (btb_tag[idx] == slot_addr[31:IDX_W+2]);
    assign slot_target[s] = btb_target[idx];
  end

  assign seq_pc = {pc[31:GRP_W] + (32 - GRP_W)'(1), {GRP_W{1'b0}}};

  // the group ends at the first predicted jump at or after the entry slot.
  always_comb begin
    found      = 1'b0;
    next_pc    = seq_pc;
    slot_valid = '0;
    slot_jump  = '0;
    for (int s = 0; s < `FETCH_SLOTS; s++) begin
      if (s >= int'(pc[GRP_W-1:2]) && !found) begin
        slot_valid[s] = 1'b1;
        if (hit[s]) begin
          slot_jump[s] = 1'b1;
          next_pc      = slot_target[s];
          found        = 1'b1;
        end
      end
    end
  end

  assign upd_idx = bpu_update.pc[IDX_W+1:2];
  assign upd_tag = bpu_update.pc[31:IDX_W+2];

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid <= '0;
    end else if (bpu_update.valid) begin
      if (bpu_update.taken) begin
        btb_valid[upd_idx] <= 1'b1;
      end else if (btb_tag[upd_idx] == upd_tag) begin
        btb_valid[upd_idx] <= 1'b0; // only drop the entry this branch owns.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bpu_update.valid && bpu_update.taken) begin
      btb_tag[upd_idx]    <= upd_tag;
      btb_target[upd_idx] <= bpu_update.target;
    end
  end

endmodule

/* fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address after reset.
`define FETCH_RESET_PC 32'h1c000000

// a fetch group is four aligned instructions, 16 bytes.
`define FETCH_SLOTS 4

`define FETCH_BTB_ENTRIES 16

// address error on fetch.
`define FETCH_ECODE_ADE 6'h8
`define FETCH_ESUB_ADEF 9'h0

// direct-map windows selected by the top three address bits.
`define FETCH_WINDOWS 2

`endif

/* fetch_if0.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_if0 (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    redirect_valid,
  input  logic [31:0]             redirect_pc,
  output logic                    req_valid,
  output logic [31:0]             req_addr,
  output logic                    req_uncached,
  input  logic                    addr_ok,
  output logic [2:0]              vseg,
  input  logic [2:0]              pseg,
  input  logic                    seg_uncached,
  output logic [31:0]             pc,
  input  logic [`FETCH_SLOTS-1:0] slot_valid,
  input  logic [`FETCH_SLOTS-1:0] slot_jump,
  input  logic [31:0]             next_pc,
  output logic                    if0_valid,
  output fetch_pkg::if0_if1_t     if0_bus,
  input  logic                    if1_ready
);

  logic [31:0]         pc_r;
  logic                misaligned;
  logic                accept;
  logic                excp_load;
  fetch_pkg::if0_if1_t bus_next;

  assign misaligned = |pc_r[1:0];
  assign req_valid  = if1_ready && !misaligned && !redirect_valid;
  assign accept     = req_valid && addr_ok;
  // a bad pc goes down the pipe as an exception, no memory access.
  assign excp_load  = misaligned && if1_ready && !redirect_valid;

  assign vseg         = pc_r[31:29];
  assign req_addr     = {pseg, pc_r[28:0]}; // only the segment bits are remapped.
  assign req_uncached = seg_uncached;
  assign pc           = pc_r;

  always_comb begin
    bus_next.pc          = pc_r;
    bus_next.slot_valid  = slot_valid;
    bus_next.slot_jump   = slot_jump;
    bus_next.pred_target = next_pc;
    bus_next.excp        = misaligned;
    bus_next.ecode       = misaligned ? `FETCH_ECODE_ADE : 6'h0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_r <= `FETCH_RESET_PC;
    end else if (redirect_valid) begin
      pc_r <= redirect_pc;
    end else if (accept) begin
      pc_r <= next_pc; // predicted or sequential group.
    end
  end

  always_ff @(posedge clk) begin
    if (rst || redirect_valid) begin
      if0_valid <= 1'b0;
    end else if (accept || excp_load) begin
      if0_valid <= 1'b1;
    end else if (if1_ready) begin
      if0_valid <= 1'b0; // IF1 took the old bus and nothing new came.
    end
  end

  always_ff @(posedge clk) begin
    if (accept || excp_load) begin
      if0_bus <= bus_next;
    end
  end

  // the predictor always opens the group at the slot the pc enters.
  a_entry_slot: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> slot_valid[pc_r[3:2]]);

endmodule

/* fetch_if1.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_if1 (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     redirect_valid,
  input  logic                     if0_valid,
  input  fetch_pkg::if0_if1_t      if0_bus,
  output logic                     if1_ready,
  input  logic                     rsp_valid,
  input  logic [127:0]             rsp_data,
  output logic                     out_valid,
  output fetch_pkg::fetch_packet_t out_packet,
  input  logic                     out_ready
);

  logic                     wait_r;     // held bus still needs its data.
  logic                     discard_r;  // next response belongs to a flushed path.
  logic                     ebuf_valid;
  logic [127:0]             ebuf;
  logic                     rsp_ok;
  logic                     absorb;
  logic                     outstanding;
  fetch_pkg::fetch_packet_t pkt_r;

  assign if1_ready  = !(wait_r || out_valid) || (out_valid && out_ready);
  assign absorb     = if0_valid && if1_ready && !redirect_valid;
  assign rsp_ok     = rsp_valid && !discard_r;
  assign out_packet = pkt_r;

  // a response may come back while its bus still sits in IF0 behind a
  // stalled packet, so ebuf keeps it until the bus moves over.
  assign outstanding = wait_r || (if0_valid && !if0_bus.excp && !ebuf_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      wait_r     <= 1'b0;
      ebuf_valid <= 1'b0;
      discard_r  <= 1'b0;
    end else if (redirect_valid) begin
      out_valid  <= 1'b0;
      wait_r     <= 1'b0;
      ebuf_valid <= 1'b0;
      discard_r  <= (discard_r || outstanding) && !rsp_valid;
    end else begin
      if (rsp_valid && discard_r) begin
        discard_r <= 1'b0;
      end
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (absorb) begin
        out_valid  <= if0_bus.excp || ebuf_valid || rsp_ok;
        wait_r     <= !(if0_bus.excp || ebuf_valid || rsp_ok);
        ebuf_valid <= 1'b0;
      end else if (wait_r && rsp_ok) begin
        wait_r    <= 1'b0;
        out_valid <= 1'b1;
      end else if (rsp_ok) begin
        ebuf_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (absorb) begin
      pkt_r.pc          <= if0_bus.pc;
      pkt_r.slot_valid  <= if0_bus.slot_valid;
      pkt_r.slot_jump   <= if0_bus.slot_jump;
      pkt_r.pred_target <= if0_bus.pred_target;
      pkt_r.excp        <= if0_bus.excp;
      pkt_r.ecode       <= if0_bus.ecode;
      pkt_r.esubcode    <= `FETCH_ESUB_ADEF; // only meaningful when excp is set.
      pkt_r.inst        <= if0_bus.excp ? 128'h0 : (ebuf_valid ? ebuf : rsp_data);
    end else if (wait_r && rsp_ok) begin
      pkt_r.inst <= rsp_data;
    end
    if (rsp_ok && !absorb && !wait_r) begin
      ebuf <= rsp_data;
    end
  end

  a_rsp_expected: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> outstanding || discard_r);

endmodule

/* fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

  typedef struct packed {
    logic [31:0]             pc;
    logic [`FETCH_SLOTS-1:0] slot_valid;
    logic [`FETCH_SLOTS-1:0] slot_jump;
    logic [31:0]             pred_target;
    logic                    excp;
    logic [5:0]              ecode;
  } if0_if1_t;

  typedef struct packed {
    logic [31:0]             pc;
    logic [127:0]            inst; // slot 0 in the low word.
    logic [`FETCH_SLOTS-1:0] slot_valid;
    logic [`FETCH_SLOTS-1:0] slot_jump;
    logic [31:0]             pred_target;
    logic                    excp;
    logic [5:0]              ecode;
    logic [8:0]              esubcode;
  } fetch_packet_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] target;
    logic        taken;
  } bpu_update_t;

  typedef struct packed {
    logic       valid;
    logic       index;
    logic [2:0] vseg;
    logic [2:0] pseg;
    logic       uncached;
    logic       enable;
  } dmw_write_t;

endpackage

/* fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_top (
  input  logic                     clk,
  input  logic                     rst,
  output logic                     req_valid,
  output logic [31:0]              req_addr,
  output logic                     req_uncached,
  input  logic                     addr_ok,
  input  logic                     rsp_valid,
  input  logic [127:0]             rsp_data,
  output logic                     out_valid,
  output fetch_pkg::fetch_packet_t out_packet,
  input  logic                     out_ready,
  input  logic                     redirect_valid,
  input  logic [31:0]              redirect_pc,
  input  fetch_pkg::bpu_update_t   bpu_update,
  input  fetch_pkg::dmw_write_t    dmw_write
);

  logic [2:0]              vseg;
  logic [2:0]              pseg;
  logic                    seg_uncached;
  logic [31:0]             pc;
  logic [`FETCH_SLOTS-1:0] slot_valid;
  logic [`FETCH_SLOTS-1:0] slot_jump;
  logic [31:0]             next_pc;
  logic                    if0_valid;
  fetch_pkg::if0_if1_t     if0_bus;
  logic                    if1_ready;

  fetch_if0 fetch_if0_inst (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_uncached   (req_uncached),
    .addr_ok        (addr_ok),
    .vseg           (vseg),
    .pseg           (pseg),
    .seg_uncached   (seg_uncached),
    .pc             (pc),
    .slot_valid     (slot_valid),
    .slot_jump      (slot_jump),
    .next_pc        (next_pc),
    .if0_valid      (if0_valid),
    .if0_bus        (if0_bus),
    .if1_ready      (if1_ready)
  );

  fetch_bpu fetch_bpu_inst (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .slot_valid (slot_valid),
    .slot_jump  (slot_jump),
    .next_pc    (next_pc),
    .bpu_update (bpu_update)
  );

  fetch_addr_map fetch_addr_map_inst (
    .clk       (clk),
    .rst       (rst),
    .vseg      (vseg),
    .pseg      (pseg),
    .uncached  (seg_uncached),
    .dmw_write (dmw_write)
  );

  fetch_if1 fetch_if1_inst (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .if0_valid      (if0_valid),
    .if0_bus        (if0_bus),
    .if1_ready      (if1_ready),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .out_valid      (out_valid),
    .out_packet     (out_packet),
    .out_ready      (out_ready)
  );

endmodule

/* tb_fetch.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module tb_fetch;

  localparam int CYCLE_LIMIT = 4000; // six tests, each well under 600 cycles.

  logic                     clk;
  logic                     rst;
  logic                     req_valid;
  logic [31:0]              req_addr;
  logic                     req_uncached;
  logic                     addr_ok;
  logic                     rsp_valid;
  logic [127:0]             rsp_data;
  logic                     out_valid;
  fetch_pkg::fetch_packet_t out_packet;
  logic                     out_ready;
  logic                     redirect_valid;
  logic [31:0]              redirect_pc;
  fetch_pkg::bpu_update_t   bpu_update;
  fetch_pkg::dmw_write_t    dmw_write;

  integer seed = 7;
  int     mode;
  int     errors;
  int     failed_tests;
  int     pkt_count;
  int     jump_count;
  int     excp_count;
  int     cycles;

  logic        mem_busy;
  int          mem_cnt;
  logic [31:0] mem_addr;

  logic [31:0]              m_pc;
  logic                     m_btb_v   [16];
  logic [25:0]              m_btb_tag [16];
  logic [31:0]              m_btb_tgt [16];
  logic                     m_win_en  [2];
  logic [2:0]               m_win_v   [2];
  logic [2:0]               m_win_p   [2];
  logic                     m_win_u   [2];
  fetch_pkg::fetch_packet_t exp_q[$];

  logic                  redir_req;
  logic [31:0]           redir_req_pc;
  logic                  dmw_req;
  fetch_pkg::dmw_write_t dmw_req_val;

  fetch_top fetch_top_inst (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_uncached   (req_uncached),
    .addr_ok        (addr_ok),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .out_valid      (out_valid),
    .out_packet     (out_packet),
    .out_ready      (out_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .bpu_update     (bpu_update),
    .dmw_write      (dmw_write)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // every word of memory is a fixed function of its physical address.
  function automatic logic [31:0] mem_word(logic [31:0] addr);
    return {addr[7:0], addr[31:8]} ^ 32'h3c5a96e1 ^ (addr << 3);
  endfunction

  function automatic logic [127:0] mem_group(logic [31:0] addr);
    logic [127:0] g;
    logic [31:0]  base;
    base = {addr[31:4], 4'h0};
    for (int i = 0; i < 4; i++) begin
      g[i*32 +: 32] = mem_word(base + 32'(i * 4));
    end
    return g;
  endfunction

  // returns {uncached, physical segment}; window 0 has priority.
  function automatic logic [3:0] translate(logic [2:0] vseg);
    logic [3:0] r;
    r = {1'b0, vseg};
    for (int w = 1; w >= 0; w--) begin
      if (m_win_en[w] && m_win_v[w] == vseg) begin
        r = {m_win_u[w], m_win_p[w]};
      end
    end
    return r;
  endfunction

  function automatic fetch_pkg::fetch_packet_t predict(logic [31:0] pc);
    fetch_pkg::fetch_packet_t p;
    logic [31:0]              a;
    logic                     done;
    int                       idx;
    p = '0;
    p.pc = pc;
    p.pred_target = {pc[31:4] + 28'd1, 4'h0};
    done = 1'b0;
    for (int s = 0; s < 4; s++) begin
      a = {pc[31:4], 2'(s), 2'b00};
      idx = int'(a[5:2]);
      if (s >= int'(pc[3:2]) && !done) begin
        p.slot_valid[s] = 1'b1;
        if (m_btb_v[idx] && m_btb_tag[idx] == a[31:6]) begin
          p.slot_jump[s] = 1'b1;
          p.pred_target = m_btb_tgt[idx];
          done = 1'b1;
        end
      end
    end
    if (pc[1:0] != 2'b00) begin
      p.excp = 1'b1;
      p.ecode = `FETCH_ECODE_ADE;
      p.esubcode = `FETCH_ESUB_ADEF;
    end
    return p;
  endfunction

  task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_packet(fetch_pkg::fetch_packet_t got, fetch_pkg::fetch_packet_t exp);
    check_value("out_packet.pc", got.pc, exp.pc);
    check_value("out_packet.inst", got.inst, exp.inst);
    check_value("out_packet.slot_valid", got.slot_valid, exp.slot_valid);
    check_value("out_packet.slot_jump", got.slot_jump, exp.slot_jump);
    check_value("out_packet.pred_target", got.pred_target, exp.pred_target);
    check_value("out_packet.excp", got.excp, exp.excp);
    check_value("out_packet.ecode", got.ecode, exp.ecode);
    check_value("out_packet.esubcode", got.esubcode, exp.esubcode);
  endtask

  always @(posedge clk) begin
    fetch_pkg::fetch_packet_t exp_pkt;
    fetch_pkg::bpu_update_t   upd;
    logic [3:0]               tr;
    int                       idx;
    if (rst) begin
      mem_busy = 1'b0;
      m_pc = `FETCH_RESET_PC;
      exp_q.delete();
      for (int i = 0; i < 16; i++) begin
        m_btb_v[i] = 1'b0;
        m_btb_tag[i] = '0;
      end
      m_win_en[0] = 1'b0;
      m_win_en[1] = 1'b0;
      rsp_valid <= 1'b0;
      addr_ok <= 1'b0;
    end else begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout: fetch stopped making progress after %0d cycles", cycles);
        $display("FAIL: see errors above");
        $finish;
      end else begin
        // decode takes a packet before any redirect in the same cycle flushes.
        if (out_valid && out_ready) begin
          pkt_count++;
          if (out_packet.slot_jump != 0) jump_count++;
          if (out_packet.excp) excp_count++;
          if (exp_q.size() > 0) begin
            check_packet(out_packet, exp_q.pop_front());
          end else if (m_pc[1:0] != 2'b00) begin
            check_packet(out_packet, predict(m_pc));
          end else begin
            $display("unexpected packet at pc %h with no request behind it", out_packet.pc);
            errors++;
          end
        end
        if (req_valid && m_pc[1:0] != 2'b00) begin
          $display("memory request issued while the pc %h is misaligned", m_pc);
          errors++;
        end
        if (req_valid && addr_ok) begin
          tr = translate(m_pc[31:29]);
          check_value("req_addr", req_addr, {tr[2:0], m_pc[28:0]});
          check_value("req_uncached", req_uncached, tr[3]);
          exp_pkt = predict(m_pc);
          exp_pkt.inst = mem_group({tr[2:0], m_pc[28:0]});
          exp_q.push_back(exp_pkt);
          m_pc = exp_pkt.pred_target;
        end
        if (redirect_valid) begin
          m_pc = redirect_pc;
          exp_q.delete();
        end
        if (bpu_update.valid) begin
          idx = int'(bpu_update.pc[5:2]);
          if (bpu_update.taken) begin
            m_btb_v[idx] = 1'b1;
            m_btb_tag[idx] = bpu_update.pc[31:6];
            m_btb_tgt[idx] = bpu_update.target;
          end else if (m_btb_tag[idx] == bpu_update.pc[31:6]) begin
            m_btb_v[idx] = 1'b0;
          end
        end
        if (dmw_write.valid) begin
          m_win_en[dmw_write.index] = dmw_write.enable;
          m_win_v[dmw_write.index] = dmw_write.vseg;
          m_win_p[dmw_write.index] = dmw_write.pseg;
          m_win_u[dmw_write.index] = dmw_write.uncached;
        end
        // memory model with one request in flight.
        if (rsp_valid) begin
          rsp_valid <= 1'b0;
          mem_busy = 1'b0;
        end else if (mem_busy) begin
          mem_cnt--;
          if (mem_cnt == 0) begin
            rsp_valid <= 1'b1;
            rsp_data <= mem_group(mem_addr);
          end
        end
        if (req_valid && addr_ok) begin
          mem_busy = 1'b1;
          mem_cnt = 1 + ($random(seed) & 3);
          mem_addr = req_addr;
        end
        if (mode == 6) addr_ok <= !mem_busy && (($random(seed) & 1) == 0);
        else addr_ok <= !mem_busy && (($random(seed) & 3) != 0);
        out_ready <= (mode == 6) ? ($random(seed) & 1) : 1'b1;
        if (redir_req) begin
          redirect_valid <= 1'b1;
          redirect_pc <= redir_req_pc;
          redir_req = 1'b0;
        end else if (mode == 3 && mem_busy && ($random(seed) & 7) == 0) begin
          redirect_valid <= 1'b1;
          redirect_pc <= 32'h1c000000 | ($random(seed) & 32'h00000ffc);
        end else begin
          redirect_valid <= 1'b0;
        end
        upd = '0;
        if (mode == 2 && ($random(seed) & 3) == 0) begin
          upd.valid = 1'b1;
          upd.pc = 32'h1c000000 | ($random(seed) & 32'h000003fc);
          upd.target = 32'h1c000000 | ($random(seed) & 32'h000003fc);
          upd.taken = ($random(seed) & 7) != 0;
        end
        bpu_update <= upd;
        if (dmw_req) begin
          dmw_write <= dmw_req_val;
          dmw_req = 1'b0;
        end else begin
          dmw_write <= '0;
        end
      end
    end
  end

  task automatic request_redirect(logic [31:0] pc);
    @(negedge clk);
    redir_req_pc = pc;
    redir_req = 1'b1;
    @(negedge clk);
  endtask

  task automatic request_dmw(logic index, logic [2:0] vseg, logic [2:0] pseg, logic unc);
    @(negedge clk);
    dmw_req_val = '0;
    dmw_req_val.valid = 1'b1;
    dmw_req_val.index = index;
    dmw_req_val.vseg = vseg;
    dmw_req_val.pseg = pseg;
    dmw_req_val.uncached = unc;
    dmw_req_val.enable = 1'b1;
    dmw_req = 1'b1;
    @(negedge clk);
  endtask

  task automatic wait_packets(int n);
    int target;
    target = pkt_count + n;
    while (pkt_count < target) @(negedge clk);
  endtask

  task automatic start_test(int m);
    @(negedge clk);
    mode = m;
    jump_count = 0;
    excp_count = 0;
  endtask

  task automatic finish_test(string name, int errors_before);
    $display("test %0d %s: %0d errors", mode, name, errors - errors_before);
    if (errors != errors_before) failed_tests++;
  endtask

  initial begin
    int e0;
    rst = 1'b1;
    addr_ok = 1'b0;
    rsp_valid = 1'b0;
    rsp_data = '0;
    out_ready = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    bpu_update = '0;
    dmw_write = '0;
    redir_req = 1'b0;
    dmw_req = 1'b0;
    mode = 0;
    errors = 0;
    failed_tests = 0;
    pkt_count = 0;
    cycles = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    e0 = errors;
    start_test(1);
    wait_packets(16);
    finish_test("sequential fetch", e0);

    e0 = errors;
    start_test(2);
    repeat (40) @(posedge clk); // time to train the BTB.
    request_redirect(32'h1c000000);
    wait_packets(40);
    if (jump_count == 0) begin
      $display("no packet with a predicted jump was seen");
      errors++;
    end
    finish_test("predicted branch", e0);

    e0 = errors;
    start_test(3);
    wait_packets(30);
    finish_test("redirect", e0);

    e0 = errors;
    start_test(4);
    request_redirect(32'h1c000102);
    wait_packets(3);
    request_redirect(32'h1c000800);
    wait_packets(4);
    if (excp_count < 3) begin
      $display("misaligned pc gave only %0d exception packets", excp_count);
      errors++;
    end
    finish_test("ADEF exception", e0);

    e0 = errors;
    start_test(5);
    request_dmw(1'b0, 3'd5, 3'd0, 1'b1);
    request_dmw(1'b1, 3'd6, 3'd2, 1'b0);
    request_redirect(32'ha0001000);
    wait_packets(4);
    request_redirect(32'hc0002000);
    wait_packets(4);
    request_redirect(32'h1c000400);
    wait_packets(4);
    finish_test("address windows", e0);

    e0 = errors;
    start_test(6);
    wait_packets(30);
    finish_test("back-pressure", e0);

    $display("tests: 6 run, %0d failed, %0d errors, %0d packets", failed_tests, errors,
             pkt_count);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
